// File: hw/ti_mem_pkg.sv
package ti_mem_pkg;

    // ------------------------------------------------------------------
    // Widths shared by the memory glue
    // ------------------------------------------------------------------

    // Byte address into the external SDRAM
    typedef logic [24:0] sdram_addr_t;
    // CPU word address
    typedef logic [18:0] cpu_addr_t;
    typedef logic [15:0] mem_data_t;
    typedef logic [7:0]  load_byte_t;
    // Active high byte lanes, bit 1 is the upper byte
    typedef logic [1:0]  byte_en_t;
    typedef logic [7:0]  img_index_t;
    typedef logic [5:0]  rom_mask_t;

    // ------------------------------------------------------------------
    // Download image index codes
    // ------------------------------------------------------------------

    localparam img_index_t IDX_C_A = 8'h02;
    localparam img_index_t IDX_C_B = 8'h01;
    localparam img_index_t IDX_D_A = 8'h03;
    localparam img_index_t IDX_D_B = 8'h41;
    localparam img_index_t IDX_G_A = 8'h04;
    localparam img_index_t IDX_G_B = 8'h81;

    // ------------------------------------------------------------------
    // SDRAM region offsets
    // ------------------------------------------------------------------

    // Cartridge port, paged
    localparam sdram_addr_t C_OFFSET   = 25'h000_0000;
    localparam sdram_addr_t D_OFFSET   = 25'h000_2000;
    // GROM area
    localparam sdram_addr_t G_OFFSET   = 25'h008_6000;
    // Full system ROM image
    localparam sdram_addr_t ROM_OFFSET = 25'h008_0000;

endpackage

// File: hw/ti_mem_ifs.sv
// Download write path from the ROM mapper to the port mux
interface load_req_if;
    logic                     wr;
    ti_mem_pkg::sdram_addr_t  addr;
    ti_mem_pkg::byte_en_t     be;
    ti_mem_pkg::mem_data_t    wdata;

    modport source (
        output wr, addr, be, wdata
    );

    modport sink (
        input  wr, addr, be, wdata
    );
endinterface

// Selected access levels towards the SDRAM request generator
interface mem_req_if;
    logic                     rd;
    logic                     we;
    ti_mem_pkg::sdram_addr_t  addr;
    ti_mem_pkg::byte_en_t     be;
    ti_mem_pkg::mem_data_t    wdata;

    modport source (
        output rd, we, addr, be, wdata
    );

    modport sink (
        input  rd, we, addr, be, wdata
    );
endinterface

// File: hw/reset_clock_ctrl.sv
module reset_clock_ctrl #(
    parameter int CLK_EN_DIV = 4
) (
    input  logic clk_sys,
    input  logic reset,
    input  logic menu_reset_i,
    input  logic button_reset_i,
    input  logic dl_active_i,
    output logic core_reset_o,
    output logic clk_en_10m7_o
);

    import ti_mem_pkg::*;

    localparam int CNT_W = (CLK_EN_DIV > 2) ? $clog2(CLK_EN_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;

    // A running download keeps the core in reset too
    always_ff @(posedge clk_sys) begin
        core_reset_o <= reset | menu_reset_i | button_reset_i | dl_active_i;
    end

    // ------------------------------------------------------------------
    // Clock enable divider
    // ------------------------------------------------------------------

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            div_cnt       <= '0;
            clk_en_10m7_o <= 1'b0;
        end else begin
            if (div_cnt == CNT_W'(CLK_EN_DIV - 1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
            // Pulse on count 1, so the first one lands two cycles out of reset
            clk_en_10m7_o <= (div_cnt == CNT_W'(1));
        end
    end

endmodule

// File: hw/rom_load_map.sv
module rom_load_map (
    input  logic                    clk_sys,
    input  logic                    reset,
    input  ti_mem_pkg::img_index_t  dl_index_i,
    input  logic                    dl_wr_i,
    input  ti_mem_pkg::sdram_addr_t dl_addr_i,
    input  ti_mem_pkg::load_byte_t  dl_data_i,
    output ti_mem_pkg::rom_mask_t   rommask_o,
    load_req_if.source              load_o
);

    import ti_mem_pkg::*;

    sdram_addr_t region_offset;
    logic        is_d_image;
    rom_mask_t   size_mask;

    // Region of the SDRAM map per image type
    always_comb begin
        if (dl_index_i == IDX_C_A || dl_index_i == IDX_C_B)
            region_offset = C_OFFSET;
        else if (dl_index_i == IDX_D_A || dl_index_i == IDX_D_B)
            region_offset = D_OFFSET;
        else if (dl_index_i == IDX_G_A || dl_index_i == IDX_G_B)
            region_offset = G_OFFSET;
        else
            region_offset = ROM_OFFSET;
    end

    assign load_o.wr    = dl_wr_i;
    assign load_o.addr  = dl_addr_i + region_offset;
    // Even byte goes to the upper lane
    assign load_o.be    = {~dl_addr_i[0], dl_addr_i[0]};
    assign load_o.wdata = {dl_data_i, dl_data_i};

    // ------------------------------------------------------------------
    // ROM page mask from the size of the last D image
    // ------------------------------------------------------------------

    assign is_d_image = (dl_index_i == IDX_D_A) || (dl_index_i == IDX_D_B);

    always_comb begin
        if (!is_d_image)
            size_mask = 6'b111111;
        else if (dl_addr_i < 25'h000_4000)
            size_mask = 6'b000001;
        else if (dl_addr_i < 25'h000_8000)
            size_mask = 6'b000011;
        else if (dl_addr_i < 25'h001_0000)
            size_mask = 6'b000111;
        else if (dl_addr_i < 25'h002_0000)
            size_mask = 6'b001111;
        else if (dl_addr_i < 25'h004_0000)
            size_mask = 6'b011111;
        else
            size_mask = 6'b111111;
    end

    always_ff @(posedge clk_sys) begin
        if (reset)
            rommask_o <= '1;
        else if (dl_wr_i)
            rommask_o <= size_mask;
    end

endmodule

// File: hw/mem_port_mux.sv
module mem_port_mux (
    input  logic                  dl_active_i,
    load_req_if.sink              load_i,
    input  ti_mem_pkg::cpu_addr_t cpu_addr_i,
    input  logic                  cpu_ce_n_i,
    input  logic                  cpu_we_n_i,
    input  ti_mem_pkg::byte_en_t  cpu_be_n_i,
    input  ti_mem_pkg::mem_data_t cpu_wdata_i,
    mem_req_if.source             mem_o
);

    import ti_mem_pkg::*;

    logic        cpu_rd;
    logic        cpu_we;
    sdram_addr_t cpu_byte_addr;

    // CPU strobes are active low
    assign cpu_we = ~(cpu_ce_n_i | cpu_we_n_i);
    assign cpu_rd = ~(cpu_ce_n_i | ~cpu_we_n_i);

    // Word address to byte address, top of the map unused by the CPU
    assign cpu_byte_addr = {5'b00000, cpu_addr_i, 1'b0};

    // ------------------------------------------------------------------
    // Port ownership
    // ------------------------------------------------------------------

    always_comb begin
        if (dl_active_i) begin
            // Loader only writes
            mem_o.rd    = 1'b0;
            mem_o.we    = load_i.wr;
            mem_o.addr  = load_i.addr;
            mem_o.be    = load_i.be;
            mem_o.wdata = load_i.wdata;
        end else begin
            mem_o.rd    = cpu_rd;
            mem_o.we    = cpu_we;
            mem_o.addr  = cpu_byte_addr;
            mem_o.be    = ~cpu_be_n_i;
            mem_o.wdata = cpu_wdata_i;
        end
    end

endmodule

// File: hw/sdram_req_toggle.sv
module sdram_req_toggle (
    input  logic                    clk_sys,
    input  logic                    reset,
    mem_req_if.sink                 mem_i,
    output logic                    sdram_req_o,
    output logic                    sdram_we_o,
    output ti_mem_pkg::sdram_addr_t sdram_addr_o,
    output ti_mem_pkg::byte_en_t    sdram_be_o,
    output ti_mem_pkg::mem_data_t   sdram_wdata_o
);

    import ti_mem_pkg::*;

    logic rd_q;
    logic we_q;
    logic new_access;

    // Rising edge of either level starts one access
    assign new_access = (mem_i.rd & ~rd_q) | (mem_i.we & ~we_q);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_q        <= 1'b0;
            we_q        <= 1'b0;
            sdram_req_o <= 1'b0;
            sdram_we_o  <= 1'b0;
        end else begin
            rd_q <= mem_i.rd;
            we_q <= mem_i.we;
            if (new_access) begin
                sdram_req_o <= ~sdram_req_o;
                sdram_we_o  <= mem_i.we;
            end
        end
    end

    // Controller samples these with the toggle
    assign sdram_addr_o  = mem_i.addr;
    assign sdram_be_o    = mem_i.be;
    assign sdram_wdata_o = mem_i.wdata;

endmodule

// File: hw/ti_mem_glue.sv
module ti_mem_glue #(
    parameter int CLK_EN_DIV = 4
) (
    input  logic                    clk_sys,
    input  logic                    reset,

    // Reset requests from the menu and the board
    input  logic                    menu_reset_i,
    input  logic                    button_reset_i,

    // ROM download port
    input  logic                    dl_active_i,
    input  ti_mem_pkg::img_index_t  dl_index_i,
    input  logic                    dl_wr_i,
    input  ti_mem_pkg::sdram_addr_t dl_addr_i,
    input  ti_mem_pkg::load_byte_t  dl_data_i,

    // CPU memory port
    input  ti_mem_pkg::cpu_addr_t   cpu_addr_i,
    input  logic                    cpu_ce_n_i,
    input  logic                    cpu_we_n_i,
    input  ti_mem_pkg::byte_en_t    cpu_be_n_i,
    input  ti_mem_pkg::mem_data_t   cpu_wdata_i,

    output logic                    core_reset_o,
    output logic                    clk_en_10m7_o,
    output ti_mem_pkg::rom_mask_t   rommask_o,

    // SDRAM controller port
    output logic                    sdram_req_o,
    output logic                    sdram_we_o,
    output ti_mem_pkg::sdram_addr_t sdram_addr_o,
    output ti_mem_pkg::byte_en_t    sdram_be_o,
    output ti_mem_pkg::mem_data_t   sdram_wdata_o
);

    import ti_mem_pkg::*;

    load_req_if load_bus ();
    mem_req_if  mem_bus ();

    // ------------------------------------------------------------------
    // Core reset and clock enable
    // ------------------------------------------------------------------

    reset_clock_ctrl #(
        .CLK_EN_DIV     (CLK_EN_DIV)
    ) u_reset_clock_ctrl (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .menu_reset_i   (menu_reset_i),
        .button_reset_i (button_reset_i),
        .dl_active_i    (dl_active_i),
        .core_reset_o   (core_reset_o),
        .clk_en_10m7_o  (clk_en_10m7_o)
    );

    // ------------------------------------------------------------------
    // Download mapping and SDRAM access path
    // ------------------------------------------------------------------

    rom_load_map u_rom_load_map (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_index_i     (dl_index_i),
        .dl_wr_i        (dl_wr_i),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .rommask_o      (rommask_o),
        .load_o         (load_bus.source)
    );

    mem_port_mux u_mem_port_mux (
        .dl_active_i    (dl_active_i),
        .load_i         (load_bus.sink),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_ce_n_i     (cpu_ce_n_i),
        .cpu_we_n_i     (cpu_we_n_i),
        .cpu_be_n_i     (cpu_be_n_i),
        .cpu_wdata_i    (cpu_wdata_i),
        .mem_o          (mem_bus.source)
    );

    sdram_req_toggle u_sdram_req_toggle (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .mem_i          (mem_bus.sink),
        .sdram_req_o    (sdram_req_o),
        .sdram_we_o     (sdram_we_o),
        .sdram_addr_o   (sdram_addr_o),
        .sdram_be_o     (sdram_be_o),
        .sdram_wdata_o  (sdram_wdata_o)
    );

endmodule

// File: dv/ti_mem_glue_properties.sv
module ti_mem_glue_properties (
    input logic clk_sys,
    input logic reset,
    input logic clk_en_i,
    input logic sdram_req_i,
    input logic sdram_we_i,
    input logic mem_rd_i,
    input logic mem_we_i
);

    int assert_failures = 0;

    // Clock enable is a single cycle pulse
    clk_en_single: assert property (@(posedge clk_sys) disable iff (reset)
        clk_en_i |=> !clk_en_i)
        else begin
            $error("clk_en_10m7_o high in two consecutive cycles");
            assert_failures++;
        end

    // Request flips in the cycle after a new access, and never otherwise
    req_on_edge: assert property (@(posedge clk_sys) disable iff (reset)
        ($rose(mem_rd_i) || $rose(mem_we_i)) |=> $changed(sdram_req_i))
        else begin
            $error("sdram_req_o did not toggle after a new access");
            assert_failures++;
        end

    req_stable: assert property (@(posedge clk_sys) disable iff (reset)
        !($rose(mem_rd_i) || $rose(mem_we_i)) |=> $stable(sdram_req_i))
        else begin
            $error("sdram_req_o toggled without a new access");
            assert_failures++;
        end

    read_flag: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(mem_rd_i) |=> !sdram_we_i)
        else begin
            $error("sdram_we_o set on a read request");
            assert_failures++;
        end

endmodule

bind ti_mem_glue ti_mem_glue_properties u_properties (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .clk_en_i    (clk_en_10m7_o),
    .sdram_req_i (sdram_req_o),
    .sdram_we_i  (sdram_we_o),
    .mem_rd_i    (mem_bus.rd),
    .mem_we_i    (mem_bus.we)
);

// File: dv/ti_mem_glue_tb.sv
module ti_mem_glue_tb;

    import ti_mem_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_EN_DIV   = 4;
    localparam int NUM_ROWS     = 19;
    localparam logic [1:0] LOAD   = 2'd0;
    localparam logic [1:0] CPU_WR = 2'd1;
    localparam logic [1:0] CPU_RD = 2'd2;

    typedef struct packed {
        logic [1:0]  mode;
        img_index_t  idx;
        sdram_addr_t addr;
        byte_en_t    be_n;
        mem_data_t   data;
        sdram_addr_t exp_addr;
        byte_en_t    exp_be;
        mem_data_t   exp_wdata;
        logic        exp_we;
        rom_mask_t   exp_mask;
    } row_t;

    logic clk_sys = 1'b0;
    logic reset, menu_reset_i, button_reset_i, dl_active_i, dl_wr_i, cpu_ce_n_i, cpu_we_n_i;
    img_index_t  dl_index_i;
    sdram_addr_t dl_addr_i;
    load_byte_t  dl_data_i;
    cpu_addr_t   cpu_addr_i;
    byte_en_t    cpu_be_n_i;
    mem_data_t   cpu_wdata_i;
    logic core_reset_o, clk_en_10m7_o, sdram_req_o, sdram_we_o;
    rom_mask_t   rommask_o;
    sdram_addr_t sdram_addr_o;
    byte_en_t    sdram_be_o;
    mem_data_t   sdram_wdata_o;

    int errors = 0;
    int tests_run = 0;
    int tests_bad = 0;
    logic [31:0] lcg_state = 32'h958e_84ba;
    row_t rows[$];

    ti_mem_glue #(.CLK_EN_DIV(CLK_EN_DIV)) uut (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_bad++;
            $display("%s: mismatch", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic add_row(input logic [1:0] mode, input img_index_t idx, input sdram_addr_t addr,
                           input byte_en_t be_n, input sdram_addr_t exp_addr,
                           input byte_en_t exp_be, input rom_mask_t exp_mask);
        row_t r;
        lcg_state = lcg_next(lcg_state);
        r.mode = mode;
        r.idx = idx;
        r.addr = addr;
        r.be_n = be_n;
        r.data = (mode == LOAD) ? {8'h00, lcg_state[23:16]} : lcg_state[31:16];
        // Loader byte lands in both halves of the word
        r.exp_wdata = (mode == LOAD) ? {r.data[7:0], r.data[7:0]} : r.data;
        r.exp_addr = exp_addr;
        r.exp_be = exp_be;
        r.exp_we = (mode != CPU_RD);
        r.exp_mask = exp_mask;
        rows.push_back(r);
    endtask

    // ------------------------------------------------------------------
    // One table step: drive, check the path, check the toggle, hold
    // ------------------------------------------------------------------

    task automatic apply_row(input row_t r, input int n);
        logic exp_req;
        int   errors_before;
        errors_before = errors;
        @(negedge clk_sys);
        exp_req = ~sdram_req_o;
        if (r.mode == LOAD) begin
            dl_active_i = 1'b1;
            dl_wr_i = 1'b1;
            dl_index_i = r.idx;
            dl_addr_i = r.addr;
            dl_data_i = r.data[7:0];
        end else begin
            cpu_ce_n_i = 1'b0;
            cpu_we_n_i = (r.mode == CPU_RD);
            cpu_addr_i = r.addr[18:0];
            cpu_be_n_i = r.be_n;
            cpu_wdata_i = r.data;
        end
        #1;
        check_eq("sdram_addr_o", sdram_addr_o, r.exp_addr);
        check_eq("sdram_be_o", sdram_be_o, r.exp_be);
        check_eq("sdram_wdata_o", sdram_wdata_o, r.exp_wdata);
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_eq("sdram_req_o", sdram_req_o, exp_req);
        check_eq("sdram_we_o", sdram_we_o, r.exp_we);
        check_eq("rommask_o", rommask_o, r.exp_mask);
        dl_wr_i = 1'b0;
        repeat (3) @(negedge clk_sys);
        // Held CPU strobe gives no second toggle
        check_eq("sdram_req_o after hold", sdram_req_o, exp_req);
        dl_active_i = 1'b0;
        cpu_ce_n_i = 1'b1;
        cpu_we_n_i = 1'b1;
        report_test($sformatf("row %0d", n), errors_before);
    endtask

    task automatic check_reset_state();
        int   errors_before;
        logic exp_en;
        errors_before = errors;
        repeat (RESET_CYCLES) @(negedge clk_sys);
        check_eq("core_reset_o in reset", core_reset_o, 1'b1);
        check_eq("sdram_req_o in reset", sdram_req_o, 1'b0);
        check_eq("sdram_we_o in reset", sdram_we_o, 1'b0);
        check_eq("rommask_o in reset", rommask_o, 6'h3f);
        reset = 1'b0;
        for (int k = 1; k <= 8; k++) begin
            @(negedge clk_sys);
            exp_en = (k >= 2) && ((k - 2) % CLK_EN_DIV == 0);
            check_eq("clk_en_10m7_o", clk_en_10m7_o, exp_en);
            check_eq("core_reset_o after reset", core_reset_o, 1'b0);
        end
        report_test("reset and clock enable", errors_before);
    endtask

    task automatic check_download_reset();
        int   errors_before;
        logic req_before;
        errors_before = errors;
        @(negedge clk_sys);
        req_before = sdram_req_o;
        dl_active_i = 1'b1;
        cpu_ce_n_i = 1'b0;
        cpu_we_n_i = 1'b0;
        repeat (3) @(negedge clk_sys);
        check_eq("core_reset_o in download", core_reset_o, 1'b1);
        check_eq("sdram_req_o in download", sdram_req_o, req_before);
        dl_active_i = 1'b0;
        cpu_ce_n_i = 1'b1;
        cpu_we_n_i = 1'b1;
        menu_reset_i = 1'b1;
        @(negedge clk_sys);
        menu_reset_i = 1'b0;
        check_eq("core_reset_o from menu", core_reset_o, 1'b1);
        @(negedge clk_sys);
        check_eq("core_reset_o released", core_reset_o, 1'b0);
        button_reset_i = 1'b1;
        @(negedge clk_sys);
        button_reset_i = 1'b0;
        check_eq("core_reset_o from button", core_reset_o, 1'b1);
        @(negedge clk_sys);
        check_eq("core_reset_o released after button", core_reset_o, 1'b0);
        check_eq("sdram_req_o after download", sdram_req_o, req_before);
        report_test("download holds core reset", errors_before);
    endtask

    initial begin
        #((NUM_ROWS * 8 + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        {menu_reset_i, button_reset_i, dl_active_i, dl_wr_i} = 4'b0000;
        dl_index_i = '0;
        dl_addr_i = '0;
        dl_data_i = '0;
        cpu_addr_i = '0;
        {cpu_ce_n_i, cpu_we_n_i, cpu_be_n_i} = 4'b1111;
        cpu_wdata_i = '0;

        // Region offsets, lanes and the size mask steps
        add_row(LOAD, 8'h02, 25'h0_0100, 2'b00, 25'h0_0100, 2'b10, 6'h3f);
        add_row(LOAD, 8'h01, 25'h0_1235, 2'b00, 25'h0_1235, 2'b01, 6'h3f);
        add_row(LOAD, 8'h03, 25'h0_0010, 2'b00, 25'h0_2010, 2'b10, 6'h01);
        add_row(LOAD, 8'h41, 25'h0_4001, 2'b00, 25'h0_6001, 2'b01, 6'h03);
        add_row(LOAD, 8'h03, 25'h0_8002, 2'b00, 25'h0_a002, 2'b10, 6'h07);
        add_row(LOAD, 8'h03, 25'h1_0003, 2'b00, 25'h1_2003, 2'b01, 6'h0f);
        add_row(LOAD, 8'h41, 25'h2_0004, 2'b00, 25'h2_2004, 2'b10, 6'h1f);
        add_row(LOAD, 8'h03, 25'h4_0005, 2'b00, 25'h4_2005, 2'b01, 6'h3f);
        add_row(LOAD, 8'h03, 25'h0_3fff, 2'b00, 25'h0_5fff, 2'b01, 6'h01);
        add_row(LOAD, 8'h02, 25'h0_0006, 2'b00, 25'h0_0006, 2'b10, 6'h3f);
        add_row(LOAD, 8'h04, 25'h0_0200, 2'b00, 25'h8_6200, 2'b10, 6'h3f);
        add_row(LOAD, 8'h81, 25'h0_1001, 2'b00, 25'h8_7001, 2'b01, 6'h3f);
        add_row(LOAD, 8'h07, 25'h0_0300, 2'b00, 25'h8_0300, 2'b10, 6'h3f);
        add_row(LOAD, 8'h00, 25'h1_0001, 2'b00, 25'h9_0001, 2'b01, 6'h3f);
        // CPU word address becomes a byte address
        add_row(CPU_WR, 8'h00, 25'h0_0123, 2'b00, 25'h0_0246, 2'b11, 6'h3f);
        add_row(CPU_RD, 8'h00, 25'h7_ffff, 2'b01, 25'hf_fffe, 2'b10, 6'h3f);
        add_row(CPU_WR, 8'h00, 25'h4_0000, 2'b10, 25'h8_0000, 2'b01, 6'h3f);
        add_row(CPU_RD, 8'h00, 25'h0_0001, 2'b11, 25'h0_0002, 2'b00, 6'h3f);
        add_row(CPU_WR, 8'h00, 25'h2_aaaa, 2'b01, 25'h5_5554, 2'b10, 6'h3f);

        check_reset_state();
        check_download_reset();
        foreach (rows[i])
            apply_row(rows[i], i);

        $display("Tests run: %0d, tests with errors: %0d, failed checks: %0d, %s %0d",
                 tests_run, tests_bad, errors, "assertion failures:",
                 uut.u_properties.assert_failures);
        if (errors == 0 && uut.u_properties.assert_failures == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: src.f
hw/ti_mem_pkg.sv
hw/ti_mem_ifs.sv
hw/reset_clock_ctrl.sv
hw/rom_load_map.sv
hw/mem_port_mux.sv
hw/sdram_req_toggle.sv
hw/ti_mem_glue.sv
dv/ti_mem_glue_properties.sv
dv/ti_mem_glue_tb.sv
